// ==== common/btb_defines.svh ====
// BTB geometry, field widths and PC bit positions
`ifndef BTB_DEFINES_SVH
`define BTB_DEFINES_SVH

// --------------------
// Geometry

// Sets per way
`define BTB_SETS 64
`define BTB_INDEX_WIDTH 6

// 2-way set associative
`define BTB_WAYS 2

// Halfword slots per fetch block
`define BTB_ENTRIES_PER_BLOCK 4

// --------------------
// Field widths

`define BTB_TAG_WIDTH 6
`define BTB_PRED_INFO_WIDTH 8

// Target PC bits 10..1
`define BTB_TARGET_WIDTH 10

`define ASID_WIDTH 9

// --------------------
// PC bit positions

// Slot select is PC bits 2..1
`define BTB_SLOT_LSB 1
`define BTB_SLOT_WIDTH 2

// Set index sits right above the slot bits, tag right above the index
`define BTB_INDEX_LSB (`BTB_SLOT_LSB + `BTB_SLOT_WIDTH)
`define BTB_TAG_LSB (`BTB_INDEX_LSB + `BTB_INDEX_WIDTH)

// Lowest stored target bit
`define BTB_TARGET_LSB 1

`endif

// ==== common/btb_pkg.sv ====
// BTB field, entry and block types
`include "btb_defines.svh"

package btb_pkg;

	// --------------------
	// Single fields

	typedef logic [`ASID_WIDTH-1:0] asid_t;

	typedef logic [`BTB_TAG_WIDTH-1:0] btb_tag_t;

	// Opaque to the BTB, owned by the predictor
	typedef logic [`BTB_PRED_INFO_WIDTH-1:0] btb_pred_info_t;

	// Low target bits only
	typedef logic [`BTB_TARGET_WIDTH-1:0] btb_target_t;

	// --------------------
	// Blocks

	// One tag per slot, slot 0 in the low bits
	typedef btb_tag_t [`BTB_ENTRIES_PER_BLOCK-1:0] btb_tag_block_t;

	// Per slot payload
	typedef struct packed {
		btb_pred_info_t pred_info;
		btb_target_t target;
	} btb_data_entry_t;

	// Payload of a whole fetch block in one way
	typedef btb_data_entry_t [`BTB_ENTRIES_PER_BLOCK-1:0] btb_data_block_t;

endpackage

// ==== btb/btb_ram.sv ====
// Synchronous RAM with a lookup read port, an update read port and a write port
`timescale 1ns/1ps

module btb_ram import btb_pkg::*; #(
	parameter type DATA_T = btb_tag_block_t,
	parameter int DEPTH = 64
) (
	input logic CLK,
	input logic nRST,

	// Lookup read
	input logic lookup_read_en,
	input logic [$clog2(DEPTH)-1:0] lookup_read_index,
	output DATA_T lookup_read_data,

	// Update read
	input logic update_read_en,
	input logic [$clog2(DEPTH)-1:0] update_read_index,
	output DATA_T update_read_data,

	// Write
	input logic write_en,
	input logic [$clog2(DEPTH)-1:0] write_index,
	input DATA_T write_data
);

	DATA_T mem [DEPTH];

	// Array contents
	always_ff @(posedge CLK) begin
		if (write_en) begin
			mem[write_index] <= write_data;
		end
	end

	// Registered read data, old contents on a same-edge write
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lookup_read_data <= '0;
			update_read_data <= '0;
		end else begin
			if (lookup_read_en) begin
				lookup_read_data <= mem[lookup_read_index];
			end
			if (update_read_en) begin
				update_read_data <= mem[update_read_index];
			end
		end
	end

endmodule

// ==== btb/btb.sv ====
// BTB core with hashing, tag compare, valid and LRU state, and update merge
`timescale 1ns/1ps
`include "btb_defines.svh"

module btb import btb_pkg::*; (
	input logic CLK,
	input logic nRST,

	// Request
	input logic valid_REQ,
	input logic [31:0] full_PC_REQ,
	input asid_t ASID_REQ,

	// Response
	output logic [`BTB_ENTRIES_PER_BLOCK-1:0] hit_by_instr_RESP,
	output btb_pred_info_t [`BTB_ENTRIES_PER_BLOCK-1:0] pred_info_by_instr_RESP,
	output logic [`BTB_ENTRIES_PER_BLOCK-1:0] pred_lru_by_instr_RESP,
	output btb_target_t [`BTB_ENTRIES_PER_BLOCK-1:0] target_by_instr_RESP,

	// Update, first cycle
	input logic update0_valid,
	input logic [31:0] update0_start_full_PC,

	// Update, second cycle
	input btb_pred_info_t update1_pred_info,
	input logic update1_pred_lru,
	input logic [31:0] update1_target_full_PC
);

	// --------------------
	// Hashing

	function automatic logic [`BTB_INDEX_WIDTH-1:0] hash_index(
		input logic [31:0] pc,
		input asid_t asid
	);
		return pc[`BTB_INDEX_LSB +: `BTB_INDEX_WIDTH] ^ asid[`BTB_INDEX_WIDTH-1:0];
	endfunction

	function automatic btb_tag_t hash_tag(
		input logic [31:0] pc,
		input asid_t asid
	);
		return pc[`BTB_TAG_LSB +: `BTB_TAG_WIDTH] ^ asid[`ASID_WIDTH-1 -: `BTB_TAG_WIDTH];
	endfunction

	// Valid and LRU per set, way and slot
	logic [`BTB_SETS-1:0][`BTB_WAYS-1:0][`BTB_ENTRIES_PER_BLOCK-1:0] valid_q;
	logic [`BTB_SETS-1:0][`BTB_ENTRIES_PER_BLOCK-1:0] lru_q;

	// ASID of the most recent valid request
	asid_t asid_q;

	logic [`BTB_INDEX_WIDTH-1:0] lookup_index;
	logic [`BTB_INDEX_WIDTH-1:0] update_index;

	// RESP stage
	logic valid_RESP;
	btb_tag_t tag_RESP;
	logic [`BTB_WAYS-1:0][`BTB_ENTRIES_PER_BLOCK-1:0] set_valid_RESP;
	logic [`BTB_ENTRIES_PER_BLOCK-1:0] set_lru_RESP;

	// Update write stage
	logic upd_valid_q;
	logic [`BTB_INDEX_WIDTH-1:0] upd_index_q;
	btb_tag_t upd_tag_q;
	logic [`BTB_SLOT_WIDTH-1:0] upd_slot_q;

	// RAM read data per way
	btb_tag_block_t lookup_tag_block [`BTB_WAYS];
	btb_data_block_t lookup_data_block [`BTB_WAYS];
	btb_tag_block_t update_tag_block [`BTB_WAYS];
	btb_data_block_t update_data_block [`BTB_WAYS];

	// Merged write blocks, shared by both ways
	logic [`BTB_WAYS-1:0] upd_match;
	logic victim_way;
	logic [`BTB_WAYS-1:0] way_write_en;
	btb_tag_block_t tag_write_block;
	btb_data_block_t data_write_block;

	assign lookup_index = hash_index(full_PC_REQ, ASID_REQ);
	assign update_index = hash_index(update0_start_full_PC, asid_q);

	// --------------------
	// Storage arrays

	for (genvar w = 0; w < `BTB_WAYS; w++) begin : gen_way
		btb_ram #(.DATA_T(btb_tag_block_t), .DEPTH(`BTB_SETS)) tag_ram (
			.CLK(CLK),
			.nRST(nRST),
			.lookup_read_en(valid_REQ),
			.lookup_read_index(lookup_index),
			.lookup_read_data(lookup_tag_block[w]),
			.update_read_en(update0_valid),
			.update_read_index(update_index),
			.update_read_data(update_tag_block[w]),
			.write_en(way_write_en[w]),
			.write_index(upd_index_q),
			.write_data(tag_write_block)
		);

		btb_ram #(.DATA_T(btb_data_block_t), .DEPTH(`BTB_SETS)) data_ram (
			.CLK(CLK),
			.nRST(nRST),
			.lookup_read_en(valid_REQ),
			.lookup_read_index(lookup_index),
			.lookup_read_data(lookup_data_block[w]),
			.update_read_en(update0_valid),
			.update_read_index(update_index),
			.update_read_data(update_data_block[w]),
			.write_en(way_write_en[w]),
			.write_index(upd_index_q),
			.write_data(data_write_block)
		);
	end

	// --------------------
	// Lookup compare

	always_comb begin
		hit_by_instr_RESP = '0;
		pred_info_by_instr_RESP = '0;
		pred_lru_by_instr_RESP = '0;
		target_by_instr_RESP = '0;
		if (valid_RESP) begin
			for (int s = 0; s < `BTB_ENTRIES_PER_BLOCK; s++) begin
				pred_lru_by_instr_RESP[s] = set_lru_RESP[s];
				// At most one way can match
				for (int w = 0; w < `BTB_WAYS; w++) begin
					if (set_valid_RESP[w][s] && lookup_tag_block[w][s] == tag_RESP) begin
						hit_by_instr_RESP[s] = 1'b1;
						pred_info_by_instr_RESP[s] = lookup_data_block[w][s].pred_info;
						target_by_instr_RESP[s] = lookup_data_block[w][s].target;
					end
				end
			end
		end
	end

	// --------------------
	// Update victim and merge

	always_comb begin
		for (int w = 0; w < `BTB_WAYS; w++) begin
			upd_match[w] = valid_q[upd_index_q][w][upd_slot_q]
				&& update_tag_block[w][upd_slot_q] == upd_tag_q;
		end

		// Matching way first, else the LRU way
		if (upd_match[0]) begin
			victim_way = 1'b0;
		end else if (upd_match[1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[upd_index_q][upd_slot_q];
		end

		for (int w = 0; w < `BTB_WAYS; w++) begin
			way_write_en[w] = upd_valid_q && (victim_way == w[0]);
		end

		tag_write_block = update_tag_block[victim_way];
		tag_write_block[upd_slot_q] = upd_tag_q;

		data_write_block = update_data_block[victim_way];
		data_write_block[upd_slot_q].pred_info = update1_pred_info;
		data_write_block[upd_slot_q].target =
			update1_target_full_PC[`BTB_TARGET_LSB +: `BTB_TARGET_WIDTH];
	end

	// --------------------
	// Control state

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			lru_q <= '0;
			asid_q <= '0;
			valid_RESP <= 1'b0;
			upd_valid_q <= 1'b0;
		end else begin
			valid_RESP <= valid_REQ;
			upd_valid_q <= update0_valid;
			if (valid_REQ) begin
				asid_q <= ASID_REQ;
			end
			// Same edge as the RAM write
			if (upd_valid_q) begin
				valid_q[upd_index_q][victim_way][upd_slot_q] <= 1'b1;
				lru_q[upd_index_q][upd_slot_q] <= update1_pred_lru;
			end
		end
	end

	// Set snapshot taken alongside the RAM reads
	always_ff @(posedge CLK) begin
		tag_RESP <= hash_tag(full_PC_REQ, ASID_REQ);
		set_valid_RESP <= valid_q[lookup_index];
		set_lru_RESP <= lru_q[lookup_index];
		upd_index_q <= update_index;
		upd_tag_q <= hash_tag(update0_start_full_PC, asid_q);
		upd_slot_q <= update0_start_full_PC[`BTB_SLOT_LSB +: `BTB_SLOT_WIDTH];
	end

endmodule

// ==== hw/btb_wrapper.sv ====
// Timing wrapper that registers every BTB input and output around the core
`timescale 1ns/1ps
`include "btb_defines.svh"

module btb_wrapper import btb_pkg::*; (
	input logic CLK,
	input logic nRST,

	// Request
	input logic next_valid_REQ,
	input logic [31:0] next_full_PC_REQ,
	input asid_t next_ASID_REQ,

	// Response
	output logic [`BTB_ENTRIES_PER_BLOCK-1:0] last_hit_by_instr_RESP,
	output btb_pred_info_t [`BTB_ENTRIES_PER_BLOCK-1:0] last_pred_info_by_instr_RESP,
	output logic [`BTB_ENTRIES_PER_BLOCK-1:0] last_pred_lru_by_instr_RESP,
	output btb_target_t [`BTB_ENTRIES_PER_BLOCK-1:0] last_target_by_instr_RESP,

	// Update
	input logic next_update0_valid,
	input logic [31:0] next_update0_start_full_PC,
	input btb_pred_info_t next_update1_pred_info,
	input logic next_update1_pred_lru,
	input logic [31:0] next_update1_target_full_PC
);

	// --------------------
	// Core side signals

	logic valid_REQ;
	logic [31:0] full_PC_REQ;
	asid_t ASID_REQ;

	logic [`BTB_ENTRIES_PER_BLOCK-1:0] hit_by_instr_RESP;
	btb_pred_info_t [`BTB_ENTRIES_PER_BLOCK-1:0] pred_info_by_instr_RESP;
	logic [`BTB_ENTRIES_PER_BLOCK-1:0] pred_lru_by_instr_RESP;
	btb_target_t [`BTB_ENTRIES_PER_BLOCK-1:0] target_by_instr_RESP;

	logic update0_valid;
	logic [31:0] update0_start_full_PC;
	btb_pred_info_t update1_pred_info;
	logic update1_pred_lru;
	logic [31:0] update1_target_full_PC;

	btb core (
		.CLK(CLK),
		.nRST(nRST),
		.valid_REQ(valid_REQ),
		.full_PC_REQ(full_PC_REQ),
		.ASID_REQ(ASID_REQ),
		.hit_by_instr_RESP(hit_by_instr_RESP),
		.pred_info_by_instr_RESP(pred_info_by_instr_RESP),
		.pred_lru_by_instr_RESP(pred_lru_by_instr_RESP),
		.target_by_instr_RESP(target_by_instr_RESP),
		.update0_valid(update0_valid),
		.update0_start_full_PC(update0_start_full_PC),
		.update1_pred_info(update1_pred_info),
		.update1_pred_lru(update1_pred_lru),
		.update1_target_full_PC(update1_target_full_PC)
	);

	// --------------------
	// Boundary registers

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_REQ <= 1'b0;
			full_PC_REQ <= '0;
			ASID_REQ <= '0;
			last_hit_by_instr_RESP <= '0;
			last_pred_info_by_instr_RESP <= '0;
			last_pred_lru_by_instr_RESP <= '0;
			last_target_by_instr_RESP <= '0;
			update0_valid <= 1'b0;
			update0_start_full_PC <= '0;
			update1_pred_info <= '0;
			update1_pred_lru <= 1'b0;
			update1_target_full_PC <= '0;
		end else begin
			// Inputs into the core
			valid_REQ <= next_valid_REQ;
			full_PC_REQ <= next_full_PC_REQ;
			ASID_REQ <= next_ASID_REQ;
			update0_valid <= next_update0_valid;
			update0_start_full_PC <= next_update0_start_full_PC;
			update1_pred_info <= next_update1_pred_info;
			update1_pred_lru <= next_update1_pred_lru;
			update1_target_full_PC <= next_update1_target_full_PC;
			// Core outputs
			last_hit_by_instr_RESP <= hit_by_instr_RESP;
			last_pred_info_by_instr_RESP <= pred_info_by_instr_RESP;
			last_pred_lru_by_instr_RESP <= pred_lru_by_instr_RESP;
			last_target_by_instr_RESP <= target_by_instr_RESP;
		end
	end

endmodule

// ==== test/btb_model.svh ====
// Reference model of the BTB contents with its hashing, victim choice and lookup
`ifndef BTB_MODEL_SVH
`define BTB_MODEL_SVH

// --------------------
// Model state per set, way and slot

logic ref_valid [`BTB_SETS][`BTB_WAYS][`BTB_ENTRIES_PER_BLOCK];
btb_tag_t ref_tag [`BTB_SETS][`BTB_WAYS][`BTB_ENTRIES_PER_BLOCK];
btb_pred_info_t ref_info [`BTB_SETS][`BTB_WAYS][`BTB_ENTRIES_PER_BLOCK];
btb_target_t ref_target [`BTB_SETS][`BTB_WAYS][`BTB_ENTRIES_PER_BLOCK];
logic ref_lru [`BTB_SETS][`BTB_ENTRIES_PER_BLOCK];

// ASID of the latest valid request, used by updates
asid_t ref_asid;

// Set index is PC bits 8..3 XOR ASID bits 5..0
function automatic logic [`BTB_INDEX_WIDTH-1:0] set_of(input logic [31:0] pc, input asid_t asid);
	return pc[8:3] ^ asid[5:0];
endfunction

// Tag is PC bits 14..9 XOR ASID bits 8..3
function automatic btb_tag_t tag_of(input logic [31:0] pc, input asid_t asid);
	return pc[14:9] ^ asid[8:3];
endfunction

function automatic void clear_model();
	ref_asid = '0;
	for (int i = 0; i < `BTB_SETS; i++) begin
		for (int s = 0; s < `BTB_ENTRIES_PER_BLOCK; s++) begin
			ref_lru[i][s] = 1'b0;
			for (int w = 0; w < `BTB_WAYS; w++) begin
				ref_valid[i][w][s] = 1'b0;
				ref_tag[i][w][s] = '0;
				ref_info[i][w][s] = '0;
				ref_target[i][w][s] = '0;
			end
		end
	end
endfunction

// Way that an update of pc would write
function automatic int victim_of(input logic [31:0] pc);
	logic [`BTB_INDEX_WIDTH-1:0] idx;
	btb_tag_t tag;
	logic [1:0] slot;
	int way;
	idx = set_of(pc, ref_asid);
	tag = tag_of(pc, ref_asid);
	slot = pc[2:1];
	way = ref_lru[idx][slot] ? 1 : 0;
	// A matching valid entry wins over the LRU way
	for (int w = 0; w < `BTB_WAYS; w++) begin
		if (ref_valid[idx][w][slot] && ref_tag[idx][w][slot] == tag) begin
			way = w;
		end
	end
	return way;
endfunction

function automatic void apply_update(input logic [31:0] pc, input btb_pred_info_t info,
		input logic lru, input logic [31:0] target_pc);
	logic [`BTB_INDEX_WIDTH-1:0] idx;
	logic [1:0] slot;
	int way;
	idx = set_of(pc, ref_asid);
	slot = pc[2:1];
	way = victim_of(pc);
	ref_valid[idx][way][slot] = 1'b1;
	ref_tag[idx][way][slot] = tag_of(pc, ref_asid);
	ref_info[idx][way][slot] = info;
	ref_target[idx][way][slot] = target_pc[10:1];
	ref_lru[idx][slot] = lru;
endfunction

function automatic void predict_lookup(input logic [31:0] pc, input asid_t asid,
		output logic [3:0] hit, output logic [31:0] info,
		output logic [3:0] lru, output logic [39:0] target);
	logic [`BTB_INDEX_WIDTH-1:0] idx;
	btb_tag_t tag;
	idx = set_of(pc, asid);
	tag = tag_of(pc, asid);
	hit = '0;
	info = '0;
	lru = '0;
	target = '0;
	for (int s = 0; s < `BTB_ENTRIES_PER_BLOCK; s++) begin
		lru[s] = ref_lru[idx][s];
		for (int w = 0; w < `BTB_WAYS; w++) begin
			if (ref_valid[idx][w][s] && ref_tag[idx][w][s] == tag) begin
				hit[s] = 1'b1;
				info[s*8 +: 8] = ref_info[idx][w][s];
				target[s*10 +: 10] = ref_target[idx][w][s];
			end
		end
	end
endfunction

`endif

// ==== test/btb_wrapper_tb.sv ====
// Testbench for the BTB wrapper with seeded random stimulus and a reference model
`timescale 1ns/1ps
`include "btb_defines.svh"

module btb_wrapper_tb import btb_pkg::*; ();

	// About 700 operations of at most 4 cycles each plus wide margin
	localparam int MAX_CYCLES = 20000;

	logic CLK;
	logic nRST;
	logic next_valid_REQ;
	logic [31:0] next_full_PC_REQ;
	asid_t next_ASID_REQ;
	logic [3:0] last_hit_by_instr_RESP;
	btb_pred_info_t [3:0] last_pred_info_by_instr_RESP;
	logic [3:0] last_pred_lru_by_instr_RESP;
	btb_target_t [3:0] last_target_by_instr_RESP;
	logic next_update0_valid;
	logic [31:0] next_update0_start_full_PC;
	btb_pred_info_t next_update1_pred_info;
	logic next_update1_pred_lru;
	logic [31:0] next_update1_target_full_PC;

	int cycle_count = 0;
	int check_count;
	int error_count;
	int test_count;
	int failed_tests;
	int errors_at_test_start;
	string current_test;

	`include "btb_model.svh"

	btb_wrapper UUT (.*);

	initial begin
		CLK = 1'b0;
		forever begin
			#4 CLK = ~CLK;
		end
	end

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	// --------------------
	// Helpers

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("Fail %s %s: expected %h, actual %h", current_test, name, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		current_test = name;
		errors_at_test_start = error_count;
		test_count++;
	endtask

	task automatic report_test();
		if (error_count != errors_at_test_start) begin
			failed_tests++;
			$display("Test %s: failed with %0d errors", current_test,
				error_count - errors_at_test_start);
		end else begin
			$display("Test %s: ok", current_test);
		end
	endtask

	// update1 follows update0 by a cycle and the write lands one edge later
	task automatic send_update(input logic [31:0] pc, input btb_pred_info_t info,
			input logic lru, input logic [31:0] target_pc);
		@(negedge CLK);
		next_update0_valid = 1'b1;
		next_update0_start_full_PC = pc;
		@(negedge CLK);
		next_update0_valid = 1'b0;
		next_update1_pred_info = info;
		next_update1_pred_lru = lru;
		next_update1_target_full_PC = target_pc;
		apply_update(pc, info, lru, target_pc);
		@(negedge CLK);
	endtask

	task automatic lookup_and_check(input logic [31:0] pc, input asid_t asid, input logic valid,
			output logic [3:0] hit_seen, output logic [31:0] info_seen);
		logic [3:0] exp_hit;
		logic [31:0] exp_info;
		logic [3:0] exp_lru;
		logic [39:0] exp_target;
		@(negedge CLK);
		next_valid_REQ = valid;
		next_full_PC_REQ = pc;
		next_ASID_REQ = asid;
		exp_hit = '0;
		exp_info = '0;
		exp_lru = '0;
		exp_target = '0;
		if (valid) begin
			ref_asid = asid;
			predict_lookup(pc, asid, exp_hit, exp_info, exp_lru, exp_target);
		end
		@(negedge CLK);
		next_valid_REQ = 1'b0;
		// Response sits in the output registers after the third edge
		repeat (2) @(negedge CLK);
		check_value("hit", 64'(exp_hit), 64'(last_hit_by_instr_RESP));
		check_value("pred_info", 64'(exp_info), 64'(last_pred_info_by_instr_RESP));
		check_value("pred_lru", 64'(exp_lru), 64'(last_pred_lru_by_instr_RESP));
		check_value("target", 64'(exp_target), 64'(last_target_by_instr_RESP));
		hit_seen = last_hit_by_instr_RESP;
		info_seen = last_pred_info_by_instr_RESP;
	endtask

	// --------------------
	// Tests

	task automatic reset_lookups();
		logic [3:0] hit;
		logic [31:0] info;
		logic [31:0] r;
		begin_test("reset_lookups");
		for (int i = 0; i < 20; i++) begin
			r = $urandom();
			lookup_and_check($urandom(), r[8:0], 1'b1, hit, info);
			check_value("hit_after_reset", 64'd0, 64'(hit));
		end
		report_test();
	endtask

	task automatic random_traffic();
		logic [3:0] hit;
		logic [31:0] info;
		logic [31:0] r;
		logic [31:0] pool [8];
		begin_test("random_traffic");
		// Tags 0..3 and sets 0..7 make ways collide often
		for (int i = 0; i < 8; i++) begin
			pool[i] = $urandom() & 32'hFFFF_861E;
		end
		for (int i = 0; i < 600; i++) begin
			r = $urandom();
			if (r[0]) begin
				send_update(pool[r[3:1]], r[15:8], r[16], $urandom());
			end else begin
				lookup_and_check(pool[r[3:1]], {6'b0, r[6:4]}, 1'b1, hit, info);
			end
		end
		report_test();
	endtask

	task automatic asid_mismatch();
		logic [3:0] hit;
		logic [31:0] info;
		logic [31:0] r;
		logic [31:0] pc;
		asid_t asid_a;
		begin_test("asid_mismatch");
		for (int i = 0; i < 8; i++) begin
			r = $urandom();
			pc = {r[31:15], 6'h15, r[8:1], 1'b0};
			asid_a = {6'b0, r[11:9]};
			lookup_and_check(pc, asid_a, 1'b1, hit, info);
			send_update(pc, r[7:0], r[12], $urandom());
			lookup_and_check(pc, asid_a, 1'b1, hit, info);
			check_value("hit_same_asid", 64'd1, 64'(hit[pc[2:1]]));
			// ASID bit 6 only moves the tag
			lookup_and_check(pc, asid_a ^ 9'h040, 1'b1, hit, info);
			check_value("hit_other_asid", 64'd0, 64'(hit[pc[2:1]]));
		end
		report_test();
	endtask

	task automatic lru_eviction();
		logic [3:0] hit;
		logic [31:0] info;
		logic [31:0] r;
		logic [31:0] u;
		logic [31:0] pcs [3];
		asid_t asid_c;
		begin_test("lru_eviction");
		r = $urandom();
		asid_c = {6'b0, r[11:9]};
		pcs[0] = {r[31:15], 6'h31, r[8:1], 1'b0};
		pcs[1] = {r[31:15], 6'h32, r[8:1], 1'b0};
		pcs[2] = {r[31:15], 6'h33, r[8:1], 1'b0};
		lookup_and_check(pcs[0], asid_c, 1'b1, hit, info);
		for (int k = 0; k < 3; k++) begin
			u = $urandom();
			send_update(pcs[k], u[7:0], u[8], u);
			for (int j = 0; j < 3; j++) begin
				lookup_and_check(pcs[j], asid_c, 1'b1, hit, info);
				if (j == k) begin
					check_value("hit_new_tag", 64'd1, 64'(hit[pcs[k][2:1]]));
				end
			end
		end
		report_test();
	endtask

	task automatic hit_overwrite();
		logic [3:0] hit;
		logic [31:0] info;
		logic [31:0] r;
		logic [31:0] u;
		logic [31:0] pc_a;
		logic [31:0] pc_b;
		logic [1:0] slot;
		asid_t asid_d;
		int way_a;
		begin_test("hit_overwrite");
		r = $urandom();
		u = $urandom();
		asid_d = {6'b0, r[11:9]};
		pc_a = {r[31:15], 6'h2a, r[8:1], 1'b0};
		pc_b = {r[31:15], 6'h2b, r[8:1], 1'b0};
		slot = pc_a[2:1];
		lookup_and_check(pc_a, asid_d, 1'b1, hit, info);
		way_a = victim_of(pc_a);
		// LRU then points at the other way where B lands and stays LRU
		send_update(pc_a, u[7:0], way_a == 0, u);
		send_update(pc_b, u[15:8], way_a == 0, u);
		send_update(pc_a, u[23:16], u[24], $urandom());
		lookup_and_check(pc_a, asid_d, 1'b1, hit, info);
		check_value("hit_rewritten", 64'd1, 64'(hit[slot]));
		check_value("info_rewritten", 64'(u[23:16]), 64'(info[slot*8 +: 8]));
		lookup_and_check(pc_b, asid_d, 1'b1, hit, info);
		check_value("hit_other_way", 64'd1, 64'(hit[slot]));
		check_value("info_other_way", 64'(u[15:8]), 64'(info[slot*8 +: 8]));
		report_test();
	endtask

	task automatic invalid_request();
		logic [3:0] hit;
		logic [31:0] info;
		logic [31:0] r;
		logic [31:0] pc;
		asid_t asid;
		begin_test("invalid_request");
		for (int i = 0; i < 4; i++) begin
			r = $urandom();
			pc = {r[31:15], 6'h3c, r[8:1], 1'b0};
			asid = {6'b0, r[11:9]};
			lookup_and_check(pc, asid, 1'b1, hit, info);
			send_update(pc, r[7:0], r[12], $urandom());
			lookup_and_check(pc, asid, 1'b1, hit, info);
			check_value("hit_with_valid", 64'd1, 64'(hit[pc[2:1]]));
			// RAM read data still holds the stored entry from the lookup above
			lookup_and_check(pc, asid, 1'b0, hit, info);
			check_value("hit_without_valid", 64'd0, 64'(hit));
		end
		report_test();
	endtask

	// --------------------
	// Main sequence

	initial begin
		void'($urandom(4746));
		nRST = 1'b0;
		next_valid_REQ = 1'b0;
		next_full_PC_REQ = '0;
		next_ASID_REQ = '0;
		next_update0_valid = 1'b0;
		next_update0_start_full_PC = '0;
		next_update1_pred_info = '0;
		next_update1_pred_lru = 1'b0;
		next_update1_target_full_PC = '0;
		check_count = 0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		clear_model();
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;

		reset_lookups();
		random_traffic();
		asid_mismatch();
		lru_eviction();
		hit_overwrite();
		invalid_request();

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== btb_wrapper.f ====
+incdir+common
+incdir+test
common/btb_pkg.sv
btb/btb_ram.sv
btb/btb.sv
hw/btb_wrapper.sv
test/btb_wrapper_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the BTB wrapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f btb_wrapper.f --top-module btb_wrapper_tb -o sim_btb_wrapper

output=$(./obj_dir/sim_btb_wrapper)
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
	exit 0
else
	exit 1
fi
